//--- filelist.f
+incdir+include
rtl/fetch_pkg.sv
rtl/inst_predecode.sv
rtl/icache_direct.sv
rtl/fetch_unit.sv
rtl/fetch_top.sv
test/fetch_checker.sv
test/tb_fetch.sv

//--- Makefile
# Verilator build and run of the fetch stage testbench

OBJ_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch \
		-f filelist.f -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/Vtb_fetch)"; echo "$$out"; \
		echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf $(OBJ_DIR)

//--- test/tb_fetch.sv
////////////////////////////////////////////////////////////////////////////
// Fetch stage testbench
// Clock, reset, bus memory with random latency, jump, IRQ and busy stimulus
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`include "fetch_macros.svh"

module tb_fetch;
	import fetch_pkg::*;

	localparam int CLOCK_PERIOD = 10;
	// Fetches in the whole run and the worst wait for one of them
	localparam int FETCH_COUNT = 64;
	localparam int WORST_FETCH_CYCLES = 40;
	localparam int TIMEOUT_NS = (FETCH_COUNT * WORST_FETCH_CYCLES + 200) * CLOCK_PERIOD;

	logic clock = 1'b0;
	logic reset;
	logic jump;
	logic [31:0] jump_pc;
	logic irq_pending;
	logic [31:0] irq_pc;
	logic irq_dispatched;
	logic [31:0] irq_epc;
	logic bus_request;
	logic bus_ready = 1'b0;
	logic [31:0] bus_address;
	logic [31:0] bus_rdata = '0;
	logic busy = 1'b0;
	fetch_data_t fetch_data;
	logic [`FETCH_COUNTER_WIDTH-1:0] icache_hit;
	logic [`FETCH_COUNTER_WIDTH-1:0] icache_miss;
	logic [2:0] phase;
	int errors;

	logic [15:0] bus_lfsr = 16'd95;
	logic [15:0] busy_lfsr = 16'd95;
	logic [15:0] stim_lfsr = 16'd95;
	logic bus_active;
	logic [1:0] bus_count;
	logic busy_enable = 1'b0;
	int busy_span;
	logic strobe_seen = 1'b0;

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	fetch_top u_dut (
		.i_clock(clock),
		.i_reset(reset),
		.i_jump(jump),
		.i_jump_pc(jump_pc),
		.i_irq_pending(irq_pending),
		.i_irq_pc(irq_pc),
		.o_irq_dispatched(irq_dispatched),
		.o_irq_epc(irq_epc),
		.o_bus_request(bus_request),
		.i_bus_ready(bus_ready),
		.o_bus_address(bus_address),
		.i_bus_rdata(bus_rdata),
		.i_busy(busy),
		.o_data(fetch_data),
		.o_icache_hit(icache_hit),
		.o_icache_miss(icache_miss)
	);

	fetch_checker u_check (
		.i_clock(clock),
		.i_reset(reset),
		.i_phase(phase),
		.i_jump(jump),
		.i_jump_pc(jump_pc),
		.i_irq_pending(irq_pending),
		.i_irq_pc(irq_pc),
		.i_irq_dispatched(irq_dispatched),
		.i_irq_epc(irq_epc),
		.i_busy(busy),
		.i_data(fetch_data),
		.i_icache_hit(icache_hit),
		.i_icache_miss(icache_miss),
		.o_errors(errors)
	);

	// Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	endfunction

	task automatic draw_bits(inout logic [15:0] state, input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++) begin
			state = lfsr_step(state);
			value = (value << 1) | int'(state[0]);
		end
	endtask

	// Bus memory, answers each request after a random delay
	always @(posedge clock) begin
		int latency;
		if (reset) begin
			bus_ready <= 1'b0;
			bus_active <= 1'b0;
			bus_count <= '0;
			bus_rdata <= '0;
		end else if (bus_ready) begin
			bus_ready <= 1'b0;
		end else if (bus_request) begin
			if (!bus_active) begin
				draw_bits(bus_lfsr, 2, latency);
				bus_count <= latency[1:0];
				bus_active <= 1'b1;
			end else if (bus_count == 0) begin
				bus_ready <= 1'b1;
				bus_rdata <= u_check.mem_word(bus_address);
				bus_active <= 1'b0;
			end else begin
				bus_count <= bus_count - 1'b1;
			end
		end
	end

	// Random busy spans from the next stage
	always @(posedge clock) begin
		int span;
		if (!busy_enable) begin
			busy <= 1'b0;
			busy_span <= 0;
		end else if (busy_span == 0) begin
			draw_bits(busy_lfsr, 3, span);
			busy <= ~busy;
			busy_span <= span;
		end else begin
			busy_span <= busy_span - 1;
		end
	end

	task automatic wait_pc(input logic [31:0] target);
		logic [31:0] pc;
		pc = 32'hFFFF_FFFF;
		while (pc != target) begin
			@(negedge clock);
			if (fetch_data.strobe != strobe_seen) begin
				strobe_seen = fetch_data.strobe;
				pc = fetch_data.pc;
			end
		end
	endtask

	task automatic idle_random();
		int cycles;
		draw_bits(stim_lfsr, 3, cycles);
		repeat (4 + cycles) @(posedge clock);
	endtask

	task automatic pulse_jump(input logic [31:0] target);
		@(posedge clock);
		jump <= 1'b1;
		jump_pc <= target;
		@(posedge clock);
		jump <= 1'b0;
	endtask

	task automatic raise_irq(input logic [31:0] vector);
		@(posedge clock);
		irq_pending <= 1'b1;
		irq_pc <= vector;
		do begin
			@(negedge clock);
		end while (!irq_dispatched);
		@(posedge clock);
		irq_pending <= 1'b0;
	endtask

	initial begin
		reset <= 1'b1;
		jump <= 1'b0;
		jump_pc <= '0;
		irq_pending <= 1'b0;
		irq_pc <= '0;
		phase <= 3'd0;
		repeat (4) @(posedge clock);
		reset <= 1'b0;
		phase <= 3'd1;
		wait_pc(32'h0000_003C);
		@(posedge clock);
		phase <= 3'd2;
		idle_random();
		pulse_jump(32'h0000_0100);
		wait_pc(32'h0000_0100);
		busy_enable = 1'b1;
		@(posedge clock);
		phase <= 3'd3;
		wait_pc(32'h0000_0140);
		busy_enable = 1'b0;
		@(posedge clock);
		phase <= 3'd4;
		pulse_jump(32'h0000_0200);
		wait_pc(32'h0000_0208);
		raise_irq(32'h0000_0400);
		// ECALL then WFI, each left only through an interrupt
		wait_pc(32'h0000_040C);
		idle_random();
		raise_irq(32'h0000_0500);
		wait_pc(32'h0000_050C);
		idle_random();
		raise_irq(32'h0000_0600);
		wait_pc(32'h0000_060C);
		@(posedge clock);
		phase <= 3'd5;
		repeat (2) begin
			idle_random();
			pulse_jump(32'h0000_0600);
			wait_pc(32'h0000_060C);
		end
		@(posedge clock);
		phase <= 3'd6;
		repeat (2) @(posedge clock);
		phase <= 3'd7;
		repeat (2) @(negedge clock);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired after %0d ns with the run unfinished", TIMEOUT_NS);
		$display("Test failed");
		$finish;
	end

endmodule

//--- test/fetch_checker.sv
////////////////////////////////////////////////////////////////////////////
// Fetch stage checker
// Memory image, reference pre-decode and cache model, compares DUT outputs
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`include "fetch_macros.svh"

module fetch_checker (
	input logic i_clock,
	input logic i_reset,
	input logic [2:0] i_phase,
	input logic i_jump,
	input logic [31:0] i_jump_pc,
	input logic i_irq_pending,
	input logic [31:0] i_irq_pc,
	input logic i_irq_dispatched,
	input logic [31:0] i_irq_epc,
	input logic i_busy,
	input fetch_pkg::fetch_data_t i_data,
	input logic [`FETCH_COUNTER_WIDTH-1:0] i_icache_hit,
	input logic [`FETCH_COUNTER_WIDTH-1:0] i_icache_miss,
	output int o_errors
);
	localparam int LINES = `FETCH_ICACHE_LINES;
	localparam int MODE_FETCH = 0;
	localparam int MODE_JUMP = 1;
	localparam int MODE_IRQ = 2;
	localparam int TEST_COUNT = 6;

	logic model_valid [LINES];
	logic [29:0] model_word [LINES];
	int model_fills;
	int mode;
	logic [31:0] expected_pc;
	logic [2:0] phase_seen;
	logic strobe_seen;
	logic busy_seen;
	logic irq_seen;
	logic dispatched_seen;
	int irq_edges;
	int dispatches;
	int test_checks;
	int test_errors;
	int total_checks;
	int total_errors;
	logic [31:0] hit_start;
	logic [31:0] miss_start;
	int fills_start;

	assign o_errors = total_errors;

	// Program image, a few control words in a field of plain instructions
	function automatic logic [31:0] mem_word(input logic [31:0] address);
		logic [31:0] mix;
		logic [6:0] opcode;
		case (address)
			32'h0000_003C: return 32'h0100_00EF;
			32'h0000_0140: return 32'h0041_8463;
			32'h0000_040C: return 32'h0000_0073;
			32'h0000_050C: return 32'h1050_0073;
			32'h0000_060C: return 32'h3020_0073;
			default: ;
		endcase
		mix = (address ^ 32'h5A5A_1234) * 32'h9E37_79B1;
		mix = mix ^ (mix >> 15);
		case (mix[31:29])
			3'd0: opcode = 7'b0110011;
			3'd1, 3'd7: opcode = 7'b0010011;
			3'd2: opcode = 7'b0000011;
			3'd3: opcode = 7'b0100011;
			3'd4: opcode = 7'b0110111;
			3'd5: opcode = 7'b0010111;
			default: opcode = 7'b1110011;
		endcase
		// SYSTEM words here are CSR accesses, funct3 nonzero
		if (opcode == 7'b1110011) begin
			return {mix[31:15], 3'b010, mix[11:7], opcode};
		end
		return {mix[31:7], opcode};
	endfunction

	// Register fields in use, packed as rs1 rs2 rd
	function automatic logic [14:0] expected_regs(input logic [31:0] word);
		logic [2:0] used;
		case (word[6:0])
			7'b0110011: used = 3'b111;
			7'b0010011, 7'b0000011, 7'b1100111: used = 3'b101;
			7'b0100011, 7'b1100011: used = 3'b110;
			7'b0110111, 7'b0010111, 7'b1101111: used = 3'b001;
			7'b1110011: used = (word[14:12] != 3'b000) ? 3'b101 : 3'b000;
			default: used = 3'b000;
		endcase
		return {used[2] ? word[19:15] : 5'd0, used[1] ? word[24:20] : 5'd0,
			used[0] ? word[11:7] : 5'd0};
	endfunction

	function automatic int next_mode(input logic [31:0] word);
		logic system_plain;
		system_plain = (word[6:0] == 7'b1110011) && (word[14:12] == 3'b000);
		if (word[6:0] inside {7'b1101111, 7'b1100111, 7'b1100011}) begin
			return MODE_JUMP;
		end
		if (system_plain && word[31:20] == 12'h302) begin
			return MODE_JUMP;
		end
		if (system_plain && (word[31:20] == 12'h000 || word[31:20] == 12'h105)) begin
			return MODE_IRQ;
		end
		return MODE_FETCH;
	endfunction

	function automatic string test_name(input int number);
		case (number)
			1: return "sequential fetch and pre-decode";
			2: return "jump wait";
			3: return "back-pressure";
			4: return "interrupt";
			5: return "loop refetch";
			default: return "cache counters";
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		test_checks++;
		total_checks++;
		if (got !== expected) begin
			$display("error at %0t ns: %s expected 0x%08h got 0x%08h",
				$time, name, expected, got);
			test_errors++;
			total_errors++;
		end
	endtask

	task automatic check_true(input logic condition, input string message);
		test_checks++;
		total_checks++;
		if (!condition) begin
			$display("failure at %0t ns: %s", $time, message);
			test_errors++;
			total_errors++;
		end
	endtask

	// Direct-mapped tag model, counts fills
	task automatic model_access(input logic [31:0] address);
		int index;
		index = int'(address[31:2]) % LINES;
		if (!model_valid[index] || model_word[index] != address[31:2]) begin
			model_valid[index] = 1'b1;
			model_word[index] = address[31:2];
			model_fills++;
		end
	endtask

	task automatic finish_test(input int number);
		case (number)
			4: check_true(irq_edges == dispatches,
				"the number of interrupt dispatches differs from the rising edges");
			5: begin
				check_true(i_icache_hit > hit_start, "the loop refetch raised no cache hits");
				check_value("o_icache_miss increase", i_icache_miss - miss_start,
					model_fills - fills_start);
			end
			6: check_value("o_icache_miss", i_icache_miss, model_fills);
			default: ;
		endcase
		$display("test %0d %s: %0d checks, %0d errors", number, test_name(number),
			test_checks, test_errors);
	endtask

	always @(negedge i_clock) begin
		logic [31:0] word;
		logic [14:0] regs;
		if (i_reset) begin
			for (int i = 0; i < LINES; i++) begin
				model_valid[i] = 1'b0;
			end
			model_fills = 0;
			mode = MODE_FETCH;
			expected_pc = `FETCH_RESET_VECTOR;
			phase_seen = i_phase;
			strobe_seen = 1'b0;
			busy_seen = 1'b0;
			irq_seen = 1'b0;
			dispatched_seen = 1'b0;
			irq_edges = 0;
			dispatches = 0;
			total_checks = 0;
			total_errors = 0;
		end else begin
			if (i_phase != phase_seen) begin
				if (phase_seen != 3'd0) begin
					finish_test(int'(phase_seen));
				end
				if (int'(i_phase) > TEST_COUNT) begin
					$display("summary: %0d tests, %0d checks, %0d errors",
						TEST_COUNT, total_checks, total_errors);
				end
				test_checks = 0;
				test_errors = 0;
				hit_start = i_icache_hit;
				miss_start = i_icache_miss;
				fills_start = model_fills;
				phase_seen = i_phase;
			end

			if (i_jump && mode == MODE_JUMP) begin
				expected_pc = i_jump_pc;
				mode = MODE_FETCH;
			end

			if (i_irq_pending && !irq_seen) begin
				irq_edges++;
			end
			irq_seen = i_irq_pending;

			if (i_irq_dispatched) begin
				check_true(!dispatched_seen, "the dispatch pulse lasted more than one cycle");
				check_true(mode != MODE_JUMP, "an interrupt was dispatched during jump wait");
				if (!dispatched_seen) begin
					dispatches++;
					check_value("o_irq_epc", i_irq_epc, expected_pc);
					// The return pc may have been filled before the redirect
					model_access(i_irq_epc);
					expected_pc = i_irq_pc;
					mode = MODE_FETCH;
				end
			end
			dispatched_seen = i_irq_dispatched;

			if (i_data.strobe != strobe_seen) begin
				strobe_seen = i_data.strobe;
				word = mem_word(i_data.pc);
				regs = expected_regs(word);
				check_true(!busy_seen, "an instruction was delivered while busy was high");
				check_true(mode == MODE_FETCH, "an instruction arrived during jump or IRQ wait");
				check_value("o_data.pc", i_data.pc, expected_pc);
				check_value("o_data.instruction", i_data.instruction, word);
				check_value("o_data.inst_rs1", {27'd0, i_data.inst_rs1}, {27'd0, regs[14:10]});
				check_value("o_data.inst_rs2", {27'd0, i_data.inst_rs2}, {27'd0, regs[9:5]});
				check_value("o_data.inst_rd", {27'd0, i_data.inst_rd}, {27'd0, regs[4:0]});
				model_access(i_data.pc);
				mode = next_mode(word);
				// Wait states keep the pc on the instruction that caused them
				if (mode == MODE_FETCH) begin
					expected_pc = i_data.pc + 32'd4;
				end else begin
					expected_pc = i_data.pc;
				end
			end
			busy_seen = i_busy;
		end
	end

endmodule

//--- rtl/fetch_top.sv
////////////////////////////////////////////////////////////////////////////
// Instruction fetch stage top level
// Joins the instruction cache, pre-decoder and fetch unit
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`include "fetch_macros.svh"

module fetch_top (
	input logic i_clock,
	input logic i_reset,
	input logic i_jump,
	input logic [31:0] i_jump_pc,
	input logic i_irq_pending,
	input logic [31:0] i_irq_pc,
	output logic o_irq_dispatched,
	output logic [31:0] o_irq_epc,
	output logic o_bus_request,
	input logic i_bus_ready,
	output logic [31:0] o_bus_address,
	input logic [31:0] i_bus_rdata,
	input logic i_busy,
	output fetch_pkg::fetch_data_t o_data,
	output logic [`FETCH_COUNTER_WIDTH-1:0] o_icache_hit,
	output logic [`FETCH_COUNTER_WIDTH-1:0] o_icache_miss
);
	import fetch_pkg::*;

	cache_resp_t resp;
	logic [31:0] fetch_pc;
	inst_class_t inst_class;
	register_t rs1;
	register_t rs2;
	register_t rd;

	icache_direct u_icache (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_pc(fetch_pc),
		.o_resp(resp),
		.o_bus_request(o_bus_request),
		.i_bus_ready(i_bus_ready),
		.o_bus_address(o_bus_address),
		.i_bus_rdata(i_bus_rdata),
		.o_hit(o_icache_hit),
		.o_miss(o_icache_miss)
	);

	// Decodes the cached word in the same cycle as the lookup
	inst_predecode u_predecode (
		.i_instruction(resp.rdata),
		.o_class(inst_class),
		.o_rs1(rs1),
		.o_rs2(rs2),
		.o_rd(rd)
	);

	fetch_unit u_fetch (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_jump(i_jump),
		.i_jump_pc(i_jump_pc),
		.i_irq_pending(i_irq_pending),
		.i_irq_pc(i_irq_pc),
		.o_irq_dispatched(o_irq_dispatched),
		.o_irq_epc(o_irq_epc),
		.i_busy(i_busy),
		.i_resp(resp),
		.i_class(inst_class),
		.i_rs1(rs1),
		.i_rs2(rs2),
		.i_rd(rd),
		.o_pc(fetch_pc),
		.o_data(o_data)
	);

endmodule

//--- rtl/fetch_unit.sv
////////////////////////////////////////////////////////////////////////////
// Fetch unit program counter FSM
// Fetches at the pc, waits for jumps and interrupts, dispatches IRQs
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`include "fetch_macros.svh"

module fetch_unit (
	input logic i_clock,
	input logic i_reset,
	input logic i_jump,
	input logic [31:0] i_jump_pc,
	input logic i_irq_pending,
	input logic [31:0] i_irq_pc,
	output logic o_irq_dispatched,
	output logic [31:0] o_irq_epc,
	input logic i_busy,
	input fetch_pkg::cache_resp_t i_resp,
	input fetch_pkg::inst_class_t i_class,
	input fetch_pkg::register_t i_rs1,
	input fetch_pkg::register_t i_rs2,
	input fetch_pkg::register_t i_rd,
	output logic [31:0] o_pc,
	output fetch_pkg::fetch_data_t o_data
);
	import fetch_pkg::*;

	typedef enum logic [1:0] {
		ST_FETCH,
		ST_WAIT_JUMP,
		ST_WAIT_IRQ
	} state_t;

	state_t state;
	logic [31:0] pc;
	fetch_data_t data;
	logic irq_pending_r;
	logic irq_edge;
	logic is_transfer;
	logic is_sleep;

	// Only a 0 to 1 transition of the pending level counts
	assign irq_edge = !irq_pending_r && i_irq_pending;

	// Execute resolves the target of these
	assign is_transfer = i_class inside {CLASS_JAL, CLASS_JALR, CLASS_B, CLASS_MRET};
	assign is_sleep = (i_class == CLASS_ECALL_WFI);

	assign o_pc = pc;
	assign o_data = data;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_FETCH;
			pc <= `FETCH_RESET_VECTOR;
			data <= '0;
			irq_pending_r <= 1'b0;
			o_irq_dispatched <= 1'b0;
			o_irq_epc <= '0;
		end else begin
			o_irq_dispatched <= 1'b0;

			case (state)
				ST_FETCH: begin
					irq_pending_r <= i_irq_pending;
					if (irq_edge) begin
						// Interrupt wins over fetch, even when busy
						o_irq_dispatched <= 1'b1;
						o_irq_epc <= pc;
						pc <= i_irq_pc;
					end else if (i_resp.ready && !i_busy) begin
						data.strobe <= ~data.strobe;
						data.pc <= pc;
						data.instruction <= i_resp.rdata;
						data.inst_rs1 <= i_rs1;
						data.inst_rs2 <= i_rs2;
						data.inst_rd <= i_rd;

						if (is_transfer) begin
							state <= ST_WAIT_JUMP;
						end else if (is_sleep) begin
							state <= ST_WAIT_IRQ;
						end else begin
							pc <= pc + 32'd4;
						end
					end
				end

				ST_WAIT_JUMP: begin
					// Pending edges are not sampled here
					if (i_jump) begin
						pc <= i_jump_pc;
						state <= ST_FETCH;
					end
				end

				ST_WAIT_IRQ: begin
					irq_pending_r <= i_irq_pending;
					if (irq_edge) begin
						// Return address is the ECALL or WFI itself
						o_irq_dispatched <= 1'b1;
						o_irq_epc <= pc;
						pc <= i_irq_pc;
						state <= ST_FETCH;
					end
				end

				default: state <= ST_FETCH;
			endcase
		end
	end

	a_dispatch_single: assert property (
		@(posedge i_clock) disable iff (i_reset)
		o_irq_dispatched |=> !o_irq_dispatched
	);

	// A new record needs a cache hit in the cycle before
	a_strobe_on_ready: assert property (
		@(posedge i_clock) disable iff (i_reset)
		!$past(i_reset) && $changed(o_data.strobe) |-> $past(i_resp.ready && !i_busy)
	);

endmodule

//--- rtl/icache_direct.sv
////////////////////////////////////////////////////////////////////////////
// Direct-mapped instruction cache, one word per line
// Combinational lookup, bus fill on a miss, hit and miss counters
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`include "fetch_macros.svh"

module icache_direct (
	input logic i_clock,
	input logic i_reset,
	input logic [31:0] i_pc,
	output fetch_pkg::cache_resp_t o_resp,
	output logic o_bus_request,
	input logic i_bus_ready,
	output logic [31:0] o_bus_address,
	input logic [31:0] i_bus_rdata,
	output logic [`FETCH_COUNTER_WIDTH-1:0] o_hit,
	output logic [`FETCH_COUNTER_WIDTH-1:0] o_miss
);
	localparam int LINES = `FETCH_ICACHE_LINES;
	localparam int INDEX_WIDTH = $clog2(LINES);
	localparam int TAG_WIDTH = 30 - INDEX_WIDTH;

	logic [LINES-1:0] line_valid;
	logic [TAG_WIDTH-1:0] line_tag [LINES];
	logic [31:0] line_data [LINES];

	logic [INDEX_WIDTH-1:0] pc_index;
	logic [TAG_WIDTH-1:0] pc_tag;
	logic [INDEX_WIDTH-1:0] fill_index;
	logic hit;
	logic fill_active;
	logic [31:0] fill_address;
	logic [31:0] pc_previous;

	// Word address split into index and tag
	assign pc_index = i_pc[INDEX_WIDTH+1:2];
	assign pc_tag = i_pc[31:INDEX_WIDTH+2];
	assign fill_index = fill_address[INDEX_WIDTH+1:2];

	assign hit = line_valid[pc_index] && (line_tag[pc_index] == pc_tag);

	assign o_resp.ready = hit;
	assign o_resp.rdata = line_data[pc_index];

	assign o_bus_request = fill_active;
	assign o_bus_address = fill_address;

	// Fill control and counters
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			line_valid <= '0;
			fill_active <= 1'b0;
			o_hit <= '0;
			o_miss <= '0;
			pc_previous <= `FETCH_RESET_VECTOR;
		end else begin
			pc_previous <= i_pc;

			// Count a hit once per new pc, not per held cycle
			if (hit && i_pc != pc_previous) begin
				o_hit <= o_hit + 1'b1;
			end

			if (fill_active) begin
				if (i_bus_ready) begin
					line_valid[fill_index] <= 1'b1;
					fill_active <= 1'b0;
					o_miss <= o_miss + 1'b1;
				end
			end else if (!hit) begin
				fill_active <= 1'b1;
			end
		end
	end

	// Line storage and latched fill address
	always_ff @(posedge i_clock) begin
		if (!fill_active && !hit) begin
			fill_address <= i_pc;
		end
		if (fill_active && i_bus_ready) begin
			line_tag[fill_index] <= fill_address[31:INDEX_WIDTH+2];
			line_data[fill_index] <= i_bus_rdata;
		end
	end

	// Request and address held until the bus answers
	property p_request_held;
		@(posedge i_clock) disable iff (i_reset)
		o_bus_request && !i_bus_ready |=> o_bus_request && $stable(o_bus_address);
	endproperty
	a_request_held: assert property (p_request_held);

	a_no_request_in_reset: assert property (
		@(posedge i_clock) i_reset |=> !o_bus_request
	);

endmodule

//--- rtl/inst_predecode.sv
////////////////////////////////////////////////////////////////////////////
// Instruction pre-decoder
// Classifies an RV32I word and extracts the register indices it uses
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module inst_predecode (
	input logic [31:0] i_instruction,
	output fetch_pkg::inst_class_t o_class,
	output fetch_pkg::register_t o_rs1,
	output fetch_pkg::register_t o_rs2,
	output fetch_pkg::register_t o_rd
);
	import fetch_pkg::*;

	// Major opcodes
	localparam logic [6:0] OP_LUI = 7'b0110111;
	localparam logic [6:0] OP_AUIPC = 7'b0010111;
	localparam logic [6:0] OP_JAL = 7'b1101111;
	localparam logic [6:0] OP_JALR = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD = 7'b0000011;
	localparam logic [6:0] OP_STORE = 7'b0100011;
	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] OP_REG = 7'b0110011;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	// SYSTEM immediates with funct3 zero
	localparam logic [11:0] F12_ECALL = 12'h000;
	localparam logic [11:0] F12_WFI = 12'h105;
	localparam logic [11:0] F12_MRET = 12'h302;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [11:0] funct12;
	logic use_rs1;
	logic use_rs2;
	logic use_rd;

	assign opcode = i_instruction[6:0];
	assign funct3 = i_instruction[14:12];
	assign funct12 = i_instruction[31:20];

	always_comb begin
		case (opcode)
			OP_REG: o_class = CLASS_R;
			OP_IMM, OP_LOAD: o_class = CLASS_I;
			OP_STORE: o_class = CLASS_S;
			OP_LUI, OP_AUIPC: o_class = CLASS_U;
			OP_BRANCH: o_class = CLASS_B;
			OP_JAL: o_class = CLASS_JAL;
			OP_JALR: o_class = CLASS_JALR;
			OP_SYSTEM: begin
				if (funct3 != 3'b000) begin
					o_class = CLASS_CSR;
				end else if (funct12 == F12_MRET) begin
					o_class = CLASS_MRET;
				end else if (funct12 == F12_ECALL || funct12 == F12_WFI) begin
					o_class = CLASS_ECALL_WFI;
				end else begin
					// EBREAK and anything unknown
					o_class = CLASS_OTHER;
				end
			end
			default: o_class = CLASS_OTHER;
		endcase
	end

	// Which fields the format really carries
	assign use_rs1 = o_class inside {CLASS_R, CLASS_I, CLASS_S, CLASS_B, CLASS_JALR, CLASS_CSR};
	assign use_rs2 = o_class inside {CLASS_R, CLASS_S, CLASS_B};
	assign use_rd = o_class inside {CLASS_R, CLASS_I, CLASS_U, CLASS_JAL, CLASS_JALR, CLASS_CSR};

	assign o_rs1 = use_rs1 ? i_instruction[19:15] : '0;
	assign o_rs2 = use_rs2 ? i_instruction[24:20] : '0;
	assign o_rd = use_rd ? i_instruction[11:7] : '0;

endmodule

//--- rtl/fetch_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Fetch stage types
// Register index, instruction class, fetch record and cache response
////////////////////////////////////////////////////////////////////////////

package fetch_pkg;

	// Integer register index, no FP banks
	typedef logic [4:0] register_t;

	// Coarse instruction class from the opcode
	typedef enum logic [3:0] {
		CLASS_R,
		CLASS_I,
		CLASS_S,
		CLASS_U,
		CLASS_B,
		CLASS_JAL,
		CLASS_JALR,
		CLASS_CSR,
		CLASS_MRET,
		CLASS_ECALL_WFI,
		CLASS_OTHER
	} inst_class_t;

	// Record handed to the next stage, strobe toggles per instruction
	typedef struct packed {
		logic strobe;
		logic [31:0] pc;
		logic [31:0] instruction;
		register_t inst_rs1;
		register_t inst_rs2;
		register_t inst_rd;
	} fetch_data_t;

	// Combinational cache lookup result
	typedef struct packed {
		logic ready;
		logic [31:0] rdata;
	} cache_resp_t;

endpackage

//--- include/fetch_macros.svh
////////////////////////////////////////////////////////////////////////////
// Fetch stage build constants
// Reset vector, instruction cache geometry and debug counter width
////////////////////////////////////////////////////////////////////////////

`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// First program counter after reset
`define FETCH_RESET_VECTOR 32'h0000_0000

// Number of cache lines, one word each, power of two
`define FETCH_ICACHE_LINES 16

// Hit and miss counter width
`define FETCH_COUNTER_WIDTH 32

`endif
